// ==== compile.f ====
+incdir+include
source/csu_types_pkg.sv
source/csu_ctrl_pkg.sv
source/csu_decoder.sv
source/csu_phys_regfile.sv
source/csu_csr_file.sv
source/csu_pipe.sv
source/csu_top.sv
test/tb_csu_top.sv

// ==== include/csu_macros.svh ====
`ifndef CSU_MACROS_SVH
`define CSU_MACROS_SVH

`define CSU_XLEN        32
`define CSU_RNID_W      5
`define CSU_ENTRY_SIZE  8
`define CSU_CSR_ADDR_W  12
`define CSU_FWD_SRCS    2  // external bus, own ex3 write.

`define CSU_MSTATUS     12'h300
`define CSU_MTVEC       12'h305
`define CSU_MSCRATCH    12'h340
`define CSU_MEPC        12'h341
`define CSU_MCAUSE      12'h342
`define CSU_MHARTID     12'hf14

`define CSU_HART_ID     0

`endif

// ==== run_sim.sh ====
#!/bin/sh
# builds the csu testbench with verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_csu_top -f compile.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vtb_csu_top 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "TESTS PASSED"; then
  exit 0
fi
exit 1

// ==== source/csu_csr_file.sv ====
`default_nettype none

`include "csu_macros.svh"

module csu_csr_file
  import csu_types_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset_n,
  input  csr_addr_t i_rd_addr,
  output xlen_t     o_rd_data,
  input  logic      i_wr_valid,
  input  csr_addr_t i_wr_addr,
  input  xlen_t     i_wr_data
);

  // uie/sie... only mie, mpie and mpp are kept.
  localparam xlen_t MSTATUS_MASK = 32'h0000_1888;

  xlen_t r_mstatus, r_mtvec, r_mscratch, r_mepc, r_mcause;
  xlen_t w_mstatus_next, w_mtvec_next, w_mscratch_next, w_mepc_next, w_mcause_next;

  always_comb begin
    w_mstatus_next  = r_mstatus;
    w_mtvec_next    = r_mtvec;
    w_mscratch_next = r_mscratch;
    w_mepc_next     = r_mepc;
    w_mcause_next   = r_mcause;
    if (i_wr_valid) begin
      case (i_wr_addr)
        `CSU_MSTATUS:  w_mstatus_next  = i_wr_data & MSTATUS_MASK;
        `CSU_MTVEC:    w_mtvec_next    = i_wr_data;
        `CSU_MSCRATCH: w_mscratch_next = i_wr_data;
        `CSU_MEPC:     w_mepc_next     = i_wr_data;
        `CSU_MCAUSE:   w_mcause_next   = i_wr_data;
        default: ;  // mhartid and unimplemented addresses.
      endcase
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_mstatus  <= '0;
      r_mtvec    <= '0;
      r_mscratch <= '0;
      r_mepc     <= '0;
      r_mcause   <= '0;
    end else begin
      r_mstatus  <= w_mstatus_next;
      r_mtvec    <= w_mtvec_next;
      r_mscratch <= w_mscratch_next;
      r_mepc     <= w_mepc_next;
      r_mcause   <= w_mcause_next;
    end
  end

  // reading the next values gives the same-cycle write bypass.
  always_comb begin
    case (i_rd_addr)
      `CSU_MSTATUS:  o_rd_data = w_mstatus_next;
      `CSU_MTVEC:    o_rd_data = w_mtvec_next;
      `CSU_MSCRATCH: o_rd_data = w_mscratch_next;
      `CSU_MEPC:     o_rd_data = w_mepc_next;
      `CSU_MCAUSE:   o_rd_data = w_mcause_next;
      `CSU_MHARTID:  o_rd_data = xlen_t'(`CSU_HART_ID);
      default:       o_rd_data = '0;
    endcase
  end

  a_wr_addr_known: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_wr_valid |-> !$isunknown(i_wr_addr));

endmodule

`default_nettype wire

// ==== source/csu_ctrl_pkg.sv ====
`default_nettype none

package csu_ctrl_pkg;

  typedef enum logic [1:0] {
    OP_NONE,
    OP_RW,
    OP_RS,
    OP_RC
  } op_t;

  typedef enum logic [2:0] {
    EXC_NONE,
    EXC_BREAKPOINT,
    EXC_ECALL_U,
    EXC_ECALL_S,
    EXC_ECALL_M,
    EXC_MRET,
    EXC_SRET,
    EXC_URET
  } except_t;

endpackage

`default_nettype wire

// ==== source/csu_decoder.sv ====
`default_nettype none

module csu_decoder
  import csu_types_pkg::*;
  import csu_ctrl_pkg::*;
(
  input  inst_t i_inst,
  output op_t   o_op,
  output logic  o_use_imm,
  output logic  o_is_ecall,
  output logic  o_is_ebreak,
  output logic  o_is_mret,
  output logic  o_is_sret,
  output logic  o_is_uret
);

  logic       w_is_system;
  logic [2:0] w_funct3;

  assign w_is_system = (i_inst[6:0] == 7'b1110011);
  assign w_funct3    = i_inst[14:12];

  always_comb begin
    o_op      = OP_NONE;
    o_use_imm = 1'b0;
    if (w_is_system) begin
      case (w_funct3[1:0])
        2'b01:   o_op = OP_RW;
        2'b10:   o_op = OP_RS;
        2'b11:   o_op = OP_RC;
        default: o_op = OP_NONE;  // funct3 0 and 4.
      endcase
      o_use_imm = w_funct3[2] & (w_funct3[1:0] != 2'b00);
    end
  end

  // privileged instructions are matched on the whole word.
  assign o_is_ecall  = (i_inst == 32'h0000_0073);
  assign o_is_ebreak = (i_inst == 32'h0010_0073);
  assign o_is_uret   = (i_inst == 32'h0020_0073);
  assign o_is_sret   = (i_inst == 32'h1020_0073);
  assign o_is_mret   = (i_inst == 32'h3020_0073);

endmodule

`default_nettype wire

// ==== source/csu_phys_regfile.sv ====
`default_nettype none

`include "csu_macros.svh"

module csu_phys_regfile
  import csu_types_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_reset_n,
  input  rnid_t i_rd_rnid,
  output xlen_t o_rd_data,
  input  logic  i_ext_wr_valid,
  input  rnid_t i_ext_wr_rnid,
  input  xlen_t i_ext_wr_data,
  input  logic  i_pipe_wr_valid,
  input  rnid_t i_pipe_wr_rnid,
  input  xlen_t i_pipe_wr_data
);

  localparam int unsigned NUM_REGS = 2 ** `CSU_RNID_W;

  xlen_t r_regs [NUM_REGS];

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        r_regs[i] <= '0;
      end
    end else begin
      if (i_pipe_wr_valid && (i_pipe_wr_rnid != '0)) r_regs[i_pipe_wr_rnid] <= i_pipe_wr_data;
      // external bus last, so it wins on a collision.
      if (i_ext_wr_valid && (i_ext_wr_rnid != '0)) r_regs[i_ext_wr_rnid] <= i_ext_wr_data;
    end
  end

  always_comb begin
    if (i_rd_rnid == '0) o_rd_data = '0;
    else if (i_ext_wr_valid && (i_ext_wr_rnid == i_rd_rnid)) o_rd_data = i_ext_wr_data;
    else if (i_pipe_wr_valid && (i_pipe_wr_rnid == i_rd_rnid)) o_rd_data = i_pipe_wr_data;
    else o_rd_data = r_regs[i_rd_rnid];
  end

  // the pipe already drops rd writes to p0.
  a_pipe_wr_not_p0: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(i_pipe_wr_valid && (i_pipe_wr_rnid == '0)));

endmodule

`default_nettype wire

// ==== source/csu_pipe.sv ====
`default_nettype none

`include "csu_macros.svh"

module csu_pipe
  import csu_types_pkg::*;
  import csu_ctrl_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset_n,
  input  logic      i_issue_valid,
  input  inst_t     i_issue_inst,
  input  entry_oh_t i_issue_index,
  input  rnid_t     i_issue_rs1_rnid,
  input  logic      i_issue_rd_valid,
  input  rnid_t     i_issue_rd_rnid,
  input  priv_t     i_priv,
  input  logic      i_ext_wr_valid,
  input  rnid_t     i_ext_wr_rnid,
  input  xlen_t     i_ext_wr_data,
  output logic      o_wakeup_valid,
  output rnid_t     o_wakeup_rnid,
  output rnid_t     o_rf_rd_rnid,
  input  xlen_t     i_rf_rd_data,
  output logic      o_rf_wr_valid,
  output rnid_t     o_rf_wr_rnid,
  output xlen_t     o_rf_wr_data,
  output csr_addr_t o_csr_rd_addr,
  input  xlen_t     i_csr_rd_data,
  output logic      o_csr_wr_valid,
  output csr_addr_t o_csr_wr_addr,
  output xlen_t     o_csr_wr_data,
  output logic      o_done,
  output entry_oh_t o_done_index,
  output logic      o_except_valid,
  output except_t   o_except_type
);

  // system flags, {ecall, ebreak, mret, sret, uret}.
  op_t        w_ex0_op, r_ex1_op, r_ex2_op, r_ex3_op;
  logic       w_ex0_use_imm, r_ex1_use_imm, r_ex2_use_imm;
  logic [4:0] w_ex0_sys, r_ex1_sys, r_ex2_sys, r_ex3_sys;
  logic       r_ex1_valid, r_ex2_valid, r_ex3_valid;
  inst_t      r_ex1_inst, r_ex2_inst, r_ex3_inst;
  entry_oh_t  r_ex1_index, r_ex2_index, r_ex3_index;
  rnid_t      r_ex1_rs1_rnid, r_ex2_rs1_rnid;
  logic       r_ex1_rd_valid, r_ex2_rd_valid, r_ex3_rd_valid;
  rnid_t      r_ex1_rd_rnid, r_ex2_rd_rnid, r_ex3_rd_rnid;
  xlen_t      r_ex2_rs1_data, r_ex3_new, r_ex3_old;

  logic [`CSU_FWD_SRCS-1:0] w_ex2_fwd_hit;
  logic  w_src_valid [`CSU_FWD_SRCS];
  rnid_t w_src_rnid  [`CSU_FWD_SRCS];
  xlen_t w_src_data  [`CSU_FWD_SRCS];
  xlen_t w_ex2_fwd_data, w_ex2_rs1_val, w_ex2_new;
  regidx_t w_ex2_rs1_idx, w_ex3_rs1_idx;

  csu_decoder u_decoder (
    .i_inst      (i_issue_inst),
    .o_op        (w_ex0_op),
    .o_use_imm   (w_ex0_use_imm),
    .o_is_ecall  (w_ex0_sys[4]),
    .o_is_ebreak (w_ex0_sys[3]),
    .o_is_mret   (w_ex0_sys[2]),
    .o_is_sret   (w_ex0_sys[1]),
    .o_is_uret   (w_ex0_sys[0])
  );

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_valid <= 1'b0;
      r_ex2_valid <= 1'b0;
      r_ex3_valid <= 1'b0;
    end else begin
      r_ex1_valid <= i_issue_valid;
      r_ex2_valid <= r_ex1_valid;
      r_ex3_valid <= r_ex2_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    {r_ex1_op, r_ex1_use_imm, r_ex1_sys} <= {w_ex0_op, w_ex0_use_imm, w_ex0_sys};
    {r_ex1_inst, r_ex1_index, r_ex1_rs1_rnid} <= {i_issue_inst, i_issue_index, i_issue_rs1_rnid};
    {r_ex1_rd_valid, r_ex1_rd_rnid} <= {i_issue_rd_valid, i_issue_rd_rnid};
    {r_ex2_op, r_ex2_use_imm, r_ex2_sys} <= {r_ex1_op, r_ex1_use_imm, r_ex1_sys};
    {r_ex2_inst, r_ex2_index, r_ex2_rs1_rnid} <= {r_ex1_inst, r_ex1_index, r_ex1_rs1_rnid};
    {r_ex2_rd_valid, r_ex2_rd_rnid} <= {r_ex1_rd_valid, r_ex1_rd_rnid};
    r_ex2_rs1_data <= i_rf_rd_data;
    {r_ex3_op, r_ex3_sys, r_ex3_inst, r_ex3_index} <= {r_ex2_op, r_ex2_sys, r_ex2_inst, r_ex2_index};
    {r_ex3_rd_valid, r_ex3_rd_rnid} <= {r_ex2_rd_valid, r_ex2_rd_rnid};
    r_ex3_new <= w_ex2_new;
    r_ex3_old <= i_csr_rd_data;
  end

  // ex1: register read and early wakeup.
  assign o_rf_rd_rnid   = r_ex1_rs1_rnid;
  assign o_wakeup_valid = r_ex1_valid & r_ex1_rd_valid;
  assign o_wakeup_rnid  = r_ex1_rd_rnid;

  // ex2: rs1 forwarding.
  assign w_src_valid[0] = i_ext_wr_valid;
  assign w_src_rnid[0]  = i_ext_wr_rnid;
  assign w_src_data[0]  = i_ext_wr_data;
  assign w_src_valid[1] = o_rf_wr_valid;
  assign w_src_rnid[1]  = o_rf_wr_rnid;
  assign w_src_data[1]  = o_rf_wr_data;

  for (genvar s = 0; s < `CSU_FWD_SRCS; s++) begin : g_fwd
    assign w_ex2_fwd_hit[s] = w_src_valid[s] & (w_src_rnid[s] == r_ex2_rs1_rnid) &
                              (r_ex2_rs1_rnid != '0);
  end

  always_comb begin
    w_ex2_fwd_data = '0;
    for (int s = 0; s < `CSU_FWD_SRCS; s++) begin
      if (w_ex2_fwd_hit[s]) w_ex2_fwd_data = w_ex2_fwd_data | w_src_data[s];
    end
  end

  assign w_ex2_rs1_idx = r_ex2_inst[19:15];
  assign w_ex2_rs1_val = r_ex2_use_imm ? {{(`CSU_XLEN-5){1'b0}}, w_ex2_rs1_idx} :
                         (|w_ex2_fwd_hit) ? w_ex2_fwd_data : r_ex2_rs1_data;
  assign o_csr_rd_addr = r_ex2_inst[31:20];

  always_comb begin
    case (r_ex2_op)
      OP_RW:   w_ex2_new = w_ex2_rs1_val;
      OP_RS:   w_ex2_new = i_csr_rd_data | w_ex2_rs1_val;
      OP_RC:   w_ex2_new = i_csr_rd_data & ~w_ex2_rs1_val;
      default: w_ex2_new = i_csr_rd_data;
    endcase
  end

  // ex3: csr write, rd write and completion.
  assign w_ex3_rs1_idx  = r_ex3_inst[19:15];
  assign o_csr_wr_valid = r_ex3_valid & (r_ex3_op != OP_NONE) &
                          !(((r_ex3_op == OP_RS) || (r_ex3_op == OP_RC)) && (w_ex3_rs1_idx == '0));
  assign o_csr_wr_addr  = r_ex3_inst[31:20];
  assign o_csr_wr_data  = r_ex3_new;

  assign o_rf_wr_valid = r_ex3_valid & r_ex3_rd_valid & (r_ex3_rd_rnid != '0);
  assign o_rf_wr_rnid  = r_ex3_rd_rnid;
  assign o_rf_wr_data  = r_ex3_old;  // rd gets the old csr value.

  assign o_done         = r_ex3_valid;
  assign o_done_index   = r_ex3_index;
  assign o_except_valid = r_ex3_valid & (|r_ex3_sys);

  always_comb begin
    if (r_ex3_sys[2]) o_except_type = EXC_MRET;
    else if (r_ex3_sys[1]) o_except_type = EXC_SRET;
    else if (r_ex3_sys[0]) o_except_type = EXC_URET;
    else if (r_ex3_sys[3]) o_except_type = EXC_BREAKPOINT;
    else if (r_ex3_sys[4]) begin
      case (i_priv)
        PRV_U:   o_except_type = EXC_ECALL_U;
        PRV_S:   o_except_type = EXC_ECALL_S;
        default: o_except_type = EXC_ECALL_M;
      endcase
    end else o_except_type = EXC_NONE;
  end

  a_fwd_single: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    r_ex2_valid |-> $onehot0(w_ex2_fwd_hit));
  a_done_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_done |-> $onehot(o_done_index));
  a_issue_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_issue_valid |-> $onehot(i_issue_index));

endmodule

`default_nettype wire

// ==== source/csu_top.sv ====
`default_nettype none

module csu_top
  import csu_types_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset_n,
  input  logic       i_issue_valid,
  input  inst_t      i_issue_inst,
  input  entry_oh_t  i_issue_index,
  input  rnid_t      i_issue_rs1_rnid,
  input  logic       i_issue_rd_valid,
  input  rnid_t      i_issue_rd_rnid,
  input  logic       i_ext_wr_valid,
  input  rnid_t      i_ext_wr_rnid,
  input  xlen_t      i_ext_wr_data,
  input  priv_t      i_priv,
  output logic       o_wakeup_valid,
  output rnid_t      o_wakeup_rnid,
  output logic       o_done,
  output entry_oh_t  o_done_index,
  output logic       o_except_valid,
  output logic [2:0] o_except_type,  // except_t encoding.
  output logic       o_wb_valid,
  output rnid_t      o_wb_rnid,
  output xlen_t      o_wb_data
);

  rnid_t     w_rf_rd_rnid;
  xlen_t     w_rf_rd_data, w_csr_rd_data, w_csr_wr_data;
  csr_addr_t w_csr_rd_addr, w_csr_wr_addr;
  logic      w_csr_wr_valid;

  csu_pipe u_pipe (
    .i_clk, .i_reset_n, .i_issue_valid, .i_issue_inst, .i_issue_index,
    .i_issue_rs1_rnid, .i_issue_rd_valid, .i_issue_rd_rnid, .i_priv,
    .i_ext_wr_valid, .i_ext_wr_rnid, .i_ext_wr_data,
    .o_wakeup_valid, .o_wakeup_rnid,
    .o_rf_rd_rnid   (w_rf_rd_rnid),
    .i_rf_rd_data   (w_rf_rd_data),
    .o_rf_wr_valid  (o_wb_valid),
    .o_rf_wr_rnid   (o_wb_rnid),
    .o_rf_wr_data   (o_wb_data),
    .o_csr_rd_addr  (w_csr_rd_addr),
    .i_csr_rd_data  (w_csr_rd_data),
    .o_csr_wr_valid (w_csr_wr_valid),
    .o_csr_wr_addr  (w_csr_wr_addr),
    .o_csr_wr_data  (w_csr_wr_data),
    .o_done, .o_done_index, .o_except_valid, .o_except_type
  );

  csu_phys_regfile u_regfile (
    .i_clk, .i_reset_n,
    .i_rd_rnid       (w_rf_rd_rnid),
    .o_rd_data       (w_rf_rd_data),
    .i_ext_wr_valid, .i_ext_wr_rnid, .i_ext_wr_data,
    .i_pipe_wr_valid (o_wb_valid),
    .i_pipe_wr_rnid  (o_wb_rnid),
    .i_pipe_wr_data  (o_wb_data)
  );

  csu_csr_file u_csr_file (
    .i_clk, .i_reset_n,
    .i_rd_addr  (w_csr_rd_addr),
    .o_rd_data  (w_csr_rd_data),
    .i_wr_valid (w_csr_wr_valid),
    .i_wr_addr  (w_csr_wr_addr),
    .i_wr_data  (w_csr_wr_data)
  );

endmodule

`default_nettype wire

// ==== source/csu_types_pkg.sv ====
`default_nettype none

`include "csu_macros.svh"

package csu_types_pkg;

  typedef logic [`CSU_XLEN-1:0]       xlen_t;
  typedef logic [`CSU_RNID_W-1:0]     rnid_t;
  typedef logic [4:0]                 regidx_t;  // architectural x0..x31.
  typedef logic [`CSU_CSR_ADDR_W-1:0] csr_addr_t;
  typedef logic [`CSU_ENTRY_SIZE-1:0] entry_oh_t;
  typedef logic [31:0]                inst_t;

  // encoding follows the privileged spec, 2 is reserved.
  typedef enum logic [1:0] {
    PRV_U = 2'd0,
    PRV_S = 2'd1,
    PRV_M = 2'd3
  } priv_t;

endpackage

`default_nettype wire

// ==== test/csu_trace.txt ====
// in:  issue_valid inst index rs1_rnid rd_valid rd_rnid ext_valid ext_rnid ext_data priv
// out: wakeup_valid wakeup_rnid done done_index except_valid except_type wb_valid wb_rnid wb_data
0 00000000 00 00 0 00 1 03 1234abcd 3   0 00 0 00 0 0 0 00 00000000
1 340110f3 01 03 1 05 0 00 00000000 3   0 00 0 00 0 0 0 00 00000000
1 34002373 02 00 1 06 1 07 f0f0f0f0 3   1 05 0 00 0 0 0 00 00000000
1 30539473 04 07 1 08 0 00 00000000 3   1 06 0 00 0 0 0 00 00000000
1 305524f3 08 0a 1 09 0 00 00000000 3   1 08 1 01 0 0 1 05 00000000
1 3054b5f3 10 09 1 0b 0 00 00000000 3   1 09 1 02 0 0 1 06 1234abcd
1 30069673 20 0d 1 0c 1 0a 0000ff0f 3   1 0b 1 04 0 0 1 08 00000000
1 30002773 40 00 1 0e 1 0d ffffffff 3   1 0c 1 08 0 0 1 09 f0f0f0f0
1 340ad7f3 80 00 1 0f 0 00 00000000 3   1 0e 1 10 0 0 1 0b f0f0ffff
1 34056873 01 00 1 10 0 00 00000000 3   1 0f 1 20 0 0 1 0c 00000000
1 3401f8f3 02 00 1 11 0 00 00000000 3   1 10 1 40 0 0 1 0e 00001888
1 30503973 04 0d 1 12 0 00 00000000 3   1 11 1 80 0 0 1 0f 1234abcd
1 f1469973 08 0d 1 13 0 00 00000000 3   1 12 1 01 0 0 1 10 00000015
1 f1402a73 10 00 1 14 0 00 00000000 3   1 13 1 02 0 0 1 11 0000001f
1 7c069a73 20 0d 1 15 0 00 00000000 3   1 14 1 04 0 0 1 12 00000f0f
1 30502b73 40 00 1 16 0 00 00000000 3   1 15 1 08 0 0 1 13 00000000
1 34169073 80 0d 0 00 0 00 00000000 3   1 16 1 10 0 0 1 14 00000000
1 00000073 01 00 0 00 0 00 00000000 3   0 00 1 20 0 0 1 15 00000000
1 00000073 02 00 0 00 0 00 00000000 3   0 00 1 40 0 0 1 16 00000f0f
1 00000073 04 00 0 00 0 00 00000000 3   0 00 1 80 0 0 0 00 00000000
1 00100073 08 00 0 00 0 00 00000000 0   0 00 1 01 1 2 0 00 00000000
1 30200073 10 00 0 00 0 00 00000000 1   0 00 1 02 1 3 0 00 00000000
1 10200073 20 00 0 00 0 00 00000000 3   0 00 1 04 1 4 0 00 00000000
1 00200073 40 00 0 00 0 00 00000000 3   0 00 1 08 1 1 0 00 00000000
1 34002bf3 80 00 1 17 0 00 00000000 3   0 00 1 10 1 5 0 00 00000000
0 00000000 00 00 0 00 0 00 00000000 3   1 17 1 20 1 6 0 00 00000000
0 00000000 00 00 0 00 0 00 00000000 3   0 00 1 40 1 7 0 00 00000000
0 00000000 00 00 0 00 0 00 00000000 3   0 00 1 80 0 0 1 17 0000001c

// ==== test/tb_csu_top.sv ====
`default_nettype none

module tb_csu_top
  import csu_types_pkg::*;
  import csu_ctrl_pkg::*;
();

  localparam int RESET_CYCLES = 5;
  localparam int NUM_LINES    = 28;
  localparam int NUM_FIELDS   = 19;  // 10 input words and 9 expected words.
  localparam int NUM_WORDS    = NUM_LINES * NUM_FIELDS;
  localparam int DRIVE_DELAY  = 2;
  localparam int SAMPLE_DELAY = 38;  // just before the next rising edge.
  localparam int MAX_CYCLES   = RESET_CYCLES + NUM_LINES + 10;

  logic       i_clk;
  logic       i_reset_n;
  logic       i_issue_valid;
  inst_t      i_issue_inst;
  entry_oh_t  i_issue_index;
  rnid_t      i_issue_rs1_rnid;
  logic       i_issue_rd_valid;
  rnid_t      i_issue_rd_rnid;
  logic       i_ext_wr_valid;
  rnid_t      i_ext_wr_rnid;
  xlen_t      i_ext_wr_data;
  priv_t      i_priv;
  logic       o_wakeup_valid;
  rnid_t      o_wakeup_rnid;
  logic       o_done;
  entry_oh_t  o_done_index;
  logic       o_except_valid;
  logic [2:0] o_except_type;
  logic       o_wb_valid;
  rnid_t      o_wb_rnid;
  xlen_t      o_wb_data;

  logic [31:0] trace_mem [NUM_WORDS];
  int          cycle_count = 0;

  csu_top DUT (.*);

  initial i_clk = 1'b0;
  always #20 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      fail_and_stop($sformatf("timeout: the trace did not finish within %0d cycles", MAX_CYCLES));
    end
  end

  task automatic fail_and_stop(input string what);
    $display("%s", what);
    $display("TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      fail_and_stop($sformatf("FAILED %s: got 0x%0h, expected 0x%0h at cycle %0d",
                              name, actual, expected, cycle_count));
    end
  endtask

  task automatic check_xlen(input string name, input xlen_t actual, input xlen_t expected);
    if (actual !== expected) begin
      fail_and_stop($sformatf("FAILED %s: got 0x%08h, expected 0x%08h at cycle %0d",
                              name, actual, expected, cycle_count));
    end
  endtask

  task automatic check_rnid(input string name, input rnid_t actual, input rnid_t expected);
    if (actual !== expected) begin
      fail_and_stop($sformatf("FAILED %s: got 0x%02h, expected 0x%02h at cycle %0d",
                              name, actual, expected, cycle_count));
    end
  endtask

  task automatic check_index(input string name, input entry_oh_t actual,
                             input entry_oh_t expected);
    if (actual !== expected) begin
      fail_and_stop($sformatf("FAILED %s: got 0x%02h, expected 0x%02h at cycle %0d",
                              name, actual, expected, cycle_count));
    end
  endtask

  task automatic check_except(input string name, input except_t actual,
                              input except_t expected);
    if (actual !== expected) begin
      fail_and_stop($sformatf("FAILED %s: got 0x%0h, expected 0x%0h at cycle %0d",
                              name, actual, expected, cycle_count));
    end
  endtask

  task automatic check_idle();
    check_bit("o_wakeup_valid", o_wakeup_valid, 1'b0);
    check_bit("o_done", o_done, 1'b0);
    check_bit("o_except_valid", o_except_valid, 1'b0);
    check_bit("o_wb_valid", o_wb_valid, 1'b0);
  endtask

  task automatic apply_line(input int line);
    int base;
    base = line * NUM_FIELDS;
    i_issue_valid    = trace_mem[base][0];
    i_issue_inst     = trace_mem[base + 1];
    i_issue_index    = trace_mem[base + 2][7:0];
    i_issue_rs1_rnid = trace_mem[base + 3][4:0];
    i_issue_rd_valid = trace_mem[base + 4][0];
    i_issue_rd_rnid  = trace_mem[base + 5][4:0];
    i_ext_wr_valid   = trace_mem[base + 6][0];
    i_ext_wr_rnid    = trace_mem[base + 7][4:0];
    i_ext_wr_data    = trace_mem[base + 8];
    i_priv           = priv_t'(trace_mem[base + 9][1:0]);  // ecall cause is taken at ex3.
  endtask

  // ids, index, cause and data are only meaningful with their strobe.
  task automatic check_line(input int line);
    int base;
    base = line * NUM_FIELDS;
    check_bit("o_wakeup_valid", o_wakeup_valid, trace_mem[base + 10][0]);
    if (trace_mem[base + 10][0]) begin
      check_rnid("o_wakeup_rnid", o_wakeup_rnid, trace_mem[base + 11][4:0]);
    end
    check_bit("o_done", o_done, trace_mem[base + 12][0]);
    if (trace_mem[base + 12][0]) begin
      check_index("o_done_index", o_done_index, trace_mem[base + 13][7:0]);
      check_except("o_except_type", except_t'(o_except_type),
                   except_t'(trace_mem[base + 15][2:0]));
    end
    check_bit("o_except_valid", o_except_valid, trace_mem[base + 14][0]);
    check_bit("o_wb_valid", o_wb_valid, trace_mem[base + 16][0]);
    if (trace_mem[base + 16][0]) begin
      check_rnid("o_wb_rnid", o_wb_rnid, trace_mem[base + 17][4:0]);
      check_xlen("o_wb_data", o_wb_data, trace_mem[base + 18]);
    end
  endtask

  initial begin
    i_reset_n        = 1'b0;
    i_issue_valid    = 1'b0;
    i_issue_inst     = '0;
    i_issue_index    = '0;
    i_issue_rs1_rnid = '0;
    i_issue_rd_valid = 1'b0;
    i_issue_rd_rnid  = '0;
    i_ext_wr_valid   = 1'b0;
    i_ext_wr_rnid    = '0;
    i_ext_wr_data    = '0;
    i_priv           = PRV_M;
    for (int i = 0; i < NUM_WORDS; i++) begin
      trace_mem[i] = 32'hbad0_0000 | 32'(i);  // marks words the file did not fill.
    end
    $readmemh("test/csu_trace.txt", trace_mem);
    if (trace_mem[NUM_WORDS - 1] == (32'hbad0_0000 | 32'(NUM_WORDS - 1))) begin
      fail_and_stop("the trace file test/csu_trace.txt is shorter than expected");
    end

    repeat (RESET_CYCLES) begin
      @(posedge i_clk);
      #(SAMPLE_DELAY);
      check_idle();
    end

    for (int line = 0; line < NUM_LINES; line++) begin
      @(posedge i_clk);
      #(DRIVE_DELAY);
      i_reset_n = 1'b1;
      apply_line(line);
      #(SAMPLE_DELAY - DRIVE_DELAY);
      check_line(line);
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire
